// ==== Bender.yml ====
package:
  name: cart_loader

sources:
  - design/cart_pkg.sv
  - design/download_decoder.sv
  - design/rom_header_parser.sv
  - design/wram_clear_sequencer.sv
  - design/work_ram.sv
  - design/cheat_code_assembler.sv
  - design/backup_ram_sequencer.sv
  - design/cart_loader_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/cart_loader_tb.sv

// ==== design/backup_ram_sequencer.sv ====
module backup_ram_sequencer import cart_pkg::*; (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              cart_active,
	input  logic              cart_start,
	input  logic              cart_end,
	input  logic [MASK_W-1:0] ram_mask,
	input  logic              img_mounted,
	input  logic              img_readonly,
	input  logic              img_size_nz,
	input  logic              osd_open,
	input  logic              autosave,
	input  logic              bk_load_req,
	input  logic              bk_save_req,
	input  logic              bsram_write,
	input  logic              sd_ack,
	output logic              sd_rd,
	output logic              sd_wr,
	output logic [31:0]       sd_lba,
	output logic              bk_busy,
	output logic              bk_pending,
	output logic              bk_enabled
);

	bk_state_e state;
	logic      ack_q, load_q, save_q;
	logic      save_req, load_go, save_go, autoload_go;
	logic      ack_rise, ack_fall, last_block, save_done;

	// Autosave fires when the OSD opens with unsaved data
	assign save_req    = bk_save_req || (bk_pending && osd_open && autosave);
	assign load_go     = bk_enabled && bk_load_req && !load_q;
	assign save_go     = bk_enabled && save_req && !save_q;
	assign autoload_go = cart_end && img_size_nz && bk_enabled;

	assign ack_rise   = sd_ack && !ack_q;
	assign ack_fall   = !sd_ack && ack_q;
	assign last_block = (sd_lba >= 32'(ram_mask[MASK_W-1:9]));
	assign save_done  = (state == BK_SAVING) && ack_fall && last_block;
	assign bk_busy    = (state != BK_IDLE);

	// ======================================================================
	// Enable and pending flags
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			bk_enabled <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			if (cart_start)
				bk_enabled <= 1'b0;
			// Save image is mounted by the end of the download
			if (cart_active && img_mounted && !img_readonly)
				bk_enabled <= |ram_mask;

			if (bsram_write && !osd_open)
				bk_pending <= 1'b1;
			else if (save_done)
				bk_pending <= 1'b0;
		end
	end

	// ======================================================================
	// SD block transfer FSM
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state  <= BK_IDLE;
			sd_rd  <= 1'b0;
			sd_wr  <= 1'b0;
			sd_lba <= '0;
			ack_q  <= 1'b0;
			load_q <= 1'b0;
			save_q <= 1'b0;
		end else begin
			ack_q  <= sd_ack;
			load_q <= bk_load_req;
			save_q <= save_req;

			// Request is withdrawn once the SD side takes it
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				BK_IDLE: begin
					if (autoload_go || load_go) begin
						state  <= BK_LOADING;
						sd_lba <= '0;
						sd_rd  <= 1'b1;
					end else if (save_go) begin
						state  <= BK_SAVING;
						sd_lba <= '0;
						sd_wr  <= 1'b1;
					end
				end
				BK_LOADING, BK_SAVING: begin
					if (ack_fall) begin
						if (last_block) begin
							state <= BK_IDLE;
						end else begin
							sd_lba <= sd_lba + 32'd1;
							sd_rd  <= (state == BK_LOADING);
							sd_wr  <= (state == BK_SAVING);
						end
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

	a_one_request: assert property (
		@(posedge clk_sys) disable iff (RESET)
		!(sd_rd && sd_wr)
	);

endmodule

// ==== design/cart_loader_top.sv ====
module cart_loader_top import cart_pkg::*; #(
	parameter int WRAM_ADDR_W = 17
) (
	input  logic                   clk_sys,
	input  logic                   RESET,

	// Host download bus
	input  logic                   dl_active,
	input  logic [7:0]             dl_index,
	input  logic [24:0]            dl_addr,
	input  logic [15:0]            dl_data,
	input  logic                   dl_wr,

	// Menu settings
	input  rom_layout_e            rom_layout,
	input  logic [1:0]             region_sel,
	input  wram_init_e             wram_init,
	input  logic                   osd_open,
	input  logic                   autosave,
	input  logic                   bk_load_req,
	input  logic                   bk_save_req,

	// SD image side
	input  logic                   img_mounted,
	input  logic                   img_readonly,
	input  logic                   img_size_nz,
	input  logic                   sd_ack,
	output logic                   sd_rd,
	output logic                   sd_wr,
	output logic [31:0]            sd_lba,

	// System side
	input  logic                   bsram_write,
	input  logic [WRAM_ADDR_W-1:0] sys_addr,
	input  logic [7:0]             sys_wdata,
	input  logic                   sys_we,
	output logic [7:0]             sys_rdata,

	output logic                   cart_active,
	output logic [7:0]             rom_type,
	output logic [MASK_W-1:0]      rom_mask,
	output logic [MASK_W-1:0]      ram_mask,
	output logic                   pal,
	output logic                   clearing,
	output logic [CHEAT_W-2:0]     cheat_code,
	output logic                   cheat_valid,
	output logic                   bk_busy,
	output logic                   bk_pending,
	output logic                   bk_enabled
);

	logic                   cart_wr, cheat_wr, cart_start, cart_end;
	logic [WRAM_ADDR_W-1:0] fill_addr;
	logic [7:0]             fill_data;
	logic                   fill_we;

	download_decoder i_download_decoder (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.dl_active   (dl_active),
		.dl_index    (dl_index),
		.dl_wr       (dl_wr),
		.cart_active (cart_active),
		.cart_wr     (cart_wr),
		.cheat_wr    (cheat_wr),
		.cart_start  (cart_start),
		.cart_end    (cart_end)
	);

	rom_header_parser i_rom_header_parser (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.cart_active (cart_active),
		.cart_wr     (cart_wr),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.rom_layout  (rom_layout),
		.region_sel  (region_sel),
		.rom_type    (rom_type),
		.rom_mask    (rom_mask),
		.ram_mask    (ram_mask),
		.pal         (pal)
	);

	wram_clear_sequencer #(.WRAM_ADDR_W(WRAM_ADDR_W)) i_wram_clear_sequencer (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.cart_start (cart_start),
		.wram_init  (wram_init),
		.clearing   (clearing),
		.fill_addr  (fill_addr),
		.fill_data  (fill_data),
		.fill_we    (fill_we)
	);

	work_ram #(.WRAM_ADDR_W(WRAM_ADDR_W)) i_work_ram (
		.clk_sys   (clk_sys),
		.sys_addr  (sys_addr),
		.sys_wdata (sys_wdata),
		.sys_we    (sys_we),
		.fill_addr (fill_addr),
		.fill_data (fill_data),
		.fill_we   (fill_we),
		.sys_rdata (sys_rdata)
	);

	cheat_code_assembler i_cheat_code_assembler (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.cheat_wr    (cheat_wr),
		.word_sel    (dl_addr[3:0]),
		.dl_data     (dl_data),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid)
	);

	backup_ram_sequencer i_backup_ram_sequencer (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.cart_active  (cart_active),
		.cart_start   (cart_start),
		.cart_end     (cart_end),
		.ram_mask     (ram_mask),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size_nz  (img_size_nz),
		.osd_open     (osd_open),
		.autosave     (autosave),
		.bk_load_req  (bk_load_req),
		.bk_save_req  (bk_save_req),
		.bsram_write  (bsram_write),
		.sd_ack       (sd_ack),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_lba       (sd_lba),
		.bk_busy      (bk_busy),
		.bk_pending   (bk_pending),
		.bk_enabled   (bk_enabled)
	);

endmodule

// ==== design/cart_pkg.sv ====
package cart_pkg;

	// ======================================================================
	// Enumerations
	// ======================================================================

	// ROM header setting from the menu
	typedef enum logic [2:0] {
		AUTO            = 3'd0,
		NO_HEADER_LOROM = 3'd1,
		LOROM           = 3'd2,
		HIROM           = 3'd3,
		EXHIROM         = 3'd4
	} rom_layout_e;

	// Power-on work-RAM contents
	typedef enum logic [1:0] {
		PATTERN_9966 = 2'd0,
		PATTERN_00FF = 2'd1,
		FILL_55      = 2'd2,
		FILL_FF      = 2'd3
	} wram_init_e;

	// Download index values, a cartridge only looks at the low six bits
	typedef enum logic [7:0] {
		STREAM_CART  = 8'h00,
		STREAM_CHEAT = 8'hFF
	} dl_stream_e;

	// Backup-RAM transfer state
	typedef enum logic [1:0] {
		BK_IDLE    = 2'd0,
		BK_LOADING = 2'd1,
		BK_SAVING  = 2'd2
	} bk_state_e;

	// ======================================================================
	// Constants
	// ======================================================================

	// Copier header in front of the ROM image
	localparam int HEADER_SKIP = 512;

	localparam int MASK_W  = 24;
	// Strobe, flags, address, compare, replace
	localparam int CHEAT_W = 129;

endpackage

// ==== design/cheat_code_assembler.sv ====
module cheat_code_assembler import cart_pkg::*; (
	input  logic               clk_sys,
	input  logic               RESET,
	input  logic               cheat_wr,
	input  logic [3:0]         word_sel,
	input  logic [15:0]        dl_data,
	output logic [CHEAT_W-2:0] cheat_code,
	output logic               cheat_valid
);

	// Fields from the top: flags, address, compare, replace
	always_ff @(posedge clk_sys) begin
		if (cheat_wr) begin
			case (word_sel)
				4'd0:  cheat_code[111:96]  <= dl_data;
				4'd2:  cheat_code[127:112] <= dl_data;
				4'd4:  cheat_code[79:64]   <= dl_data;
				4'd6:  cheat_code[95:80]   <= dl_data;
				4'd8:  cheat_code[47:32]   <= dl_data;
				4'd10: cheat_code[63:48]   <= dl_data;
				4'd12: cheat_code[15:0]    <= dl_data;
				4'd14: cheat_code[31:16]   <= dl_data;
				default: ;
			endcase
		end
	end

	// The last word clocks the code into the system
	always_ff @(posedge clk_sys) begin
		if (RESET)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= cheat_wr && (word_sel == 4'd14);
	end

endmodule

// ==== design/download_decoder.sv ====
module download_decoder import cart_pkg::*; (
	input  logic       clk_sys,
	input  logic       RESET,
	input  logic       dl_active,
	input  logic [7:0] dl_index,
	input  logic       dl_wr,
	output logic       cart_active,
	output logic       cart_wr,
	output logic       cheat_wr,
	output logic       cart_start,
	output logic       cart_end
);

	localparam logic [7:0] CART_IDX = STREAM_CART;

	logic cart_active_q;

	// Stream classification by index
	assign cart_active = dl_active && (dl_index[5:0] == CART_IDX[5:0]);
	assign cart_wr     = cart_active && dl_wr;
	assign cheat_wr    = dl_active && (dl_index == STREAM_CHEAT) && dl_wr;

	// Edge pulses, one cycle behind the level
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_active_q <= 1'b0;
			cart_start    <= 1'b0;
			cart_end      <= 1'b0;
		end else begin
			cart_active_q <= cart_active;
			cart_start    <= cart_active && !cart_active_q;
			cart_end      <= !cart_active && cart_active_q;
		end
	end

endmodule

// ==== design/rom_header_parser.sv ====
module rom_header_parser import cart_pkg::*; (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              cart_active,
	input  logic              cart_wr,
	input  logic [24:0]       dl_addr,
	input  logic [15:0]       dl_data,
	input  rom_layout_e       rom_layout,
	input  logic [1:0]        region_sel,
	output logic [7:0]        rom_type,
	output logic [MASK_W-1:0] rom_mask,
	output logic [MASK_W-1:0] ram_mask,
	output logic              pal
);

	// Size field locations inside the downloaded image
	localparam logic [24:0] LO_ROM_ADDR = 25'(HEADER_SKIP + 'h7FD6);
	localparam logic [24:0] LO_RAM_ADDR = 25'(HEADER_SKIP + 'h7FD8);
	localparam logic [24:0] HI_ROM_ADDR = 25'(HEADER_SKIP + 'hFFD6);
	localparam logic [24:0] HI_RAM_ADDR = 25'(HEADER_SKIP + 'hFFD8);
	localparam logic [24:0] EX_ROM_ADDR = 25'(HEADER_SKIP + 'h40FFD6);
	localparam logic [24:0] EX_RAM_ADDR = 25'(HEADER_SKIP + 'h40FFD8);

	logic [3:0]  rom_size, ram_size;
	logic [3:0]  rom_size_nxt, ram_size_nxt;
	logic [24:0] rom_size_addr, ram_size_addr;
	logic        hdr_fields;
	logic        rom_region;

	always_comb begin
		hdr_fields    = 1'b1;
		rom_size_addr = LO_ROM_ADDR;
		ram_size_addr = LO_RAM_ADDR;
		case (rom_layout)
			HIROM: begin
				rom_size_addr = HI_ROM_ADDR;
				ram_size_addr = HI_RAM_ADDR;
			end
			EXHIROM: begin
				rom_size_addr = EX_ROM_ADDR;
				ram_size_addr = EX_RAM_ADDR;
			end
			LOROM: hdr_fields = 1'b1;
			default: hdr_fields = 1'b0;
		endcase
	end

	// Next size codes, so the masks follow the write that changed them
	always_comb begin
		rom_size_nxt = rom_size;
		ram_size_nxt = ram_size;
		if (cart_wr) begin
			if (dl_addr == '0) begin
				rom_size_nxt = 4'hC;
				ram_size_nxt = 4'h0;
				if (rom_layout == AUTO && dl_data[7:0] != 8'h00)
					{ram_size_nxt, rom_size_nxt} = dl_data[7:0];
			end
			if (hdr_fields && dl_addr == rom_size_addr)
				rom_size_nxt = dl_data[11:8];
			if (hdr_fields && dl_addr == ram_size_addr)
				ram_size_nxt = dl_data[3:0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= 4'hC;
			ram_size   <= 4'h0;
			rom_type   <= 8'h00;
			rom_mask   <= '0;
			ram_mask   <= '0;
			rom_region <= 1'b0;
			pal        <= 1'b0;
		end else if (cart_active) begin
			rom_size <= rom_size_nxt;
			ram_size <= ram_size_nxt;
			if (cart_wr) begin
				if (dl_addr == '0) begin
					case (rom_layout)
						NO_HEADER_LOROM, LOROM: rom_type <= 8'd0;
						HIROM:                  rom_type <= 8'd1;
						EXHIROM:                rom_type <= 8'd2;
						default:                rom_type <= dl_data[15:8];
					endcase
				end
				if (dl_addr == 25'd2)
					rom_region <= dl_data[8];
				rom_mask <= (MASK_W'(1024) << rom_size_nxt) - MASK_W'(1);
				ram_mask <= (ram_size_nxt != 4'h0) ?
					(MASK_W'(1024) << ram_size_nxt) - MASK_W'(1) : '0;
			end
		end else begin
			// 1 is NTSC, 2 and 3 force PAL
			pal <= (region_sel == 2'd0) ? rom_region : region_sel[1];
		end
	end

endmodule

// ==== design/work_ram.sv ====
module work_ram #(
	parameter int WRAM_ADDR_W = 17
) (
	input  logic                   clk_sys,
	input  logic [WRAM_ADDR_W-1:0] sys_addr,
	input  logic [7:0]             sys_wdata,
	input  logic                   sys_we,
	input  logic [WRAM_ADDR_W-1:0] fill_addr,
	input  logic [7:0]             fill_data,
	input  logic                   fill_we,
	output logic [7:0]             sys_rdata
);

	logic [7:0] mem [2**WRAM_ADDR_W];

	// Fill port is written last so it wins on a shared address
	always_ff @(posedge clk_sys) begin
		if (sys_we)
			mem[sys_addr] <= sys_wdata;
		if (fill_we)
			mem[fill_addr] <= fill_data;
	end

	// Registered read, old data on a same-cycle write
	always_ff @(posedge clk_sys) begin
		sys_rdata <= mem[sys_addr];
	end

endmodule

// ==== design/wram_clear_sequencer.sv ====
module wram_clear_sequencer import cart_pkg::*; #(
	parameter int WRAM_ADDR_W = 17
) (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  logic                   cart_start,
	input  wram_init_e             wram_init,
	output logic                   clearing,
	output logic [WRAM_ADDR_W-1:0] fill_addr,
	output logic [7:0]             fill_data,
	output logic                   fill_we
);

	// One write per cycle from address zero up to all ones
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			clearing  <= 1'b0;
			fill_addr <= '0;
		end else begin
			if (cart_start)
				clearing <= 1'b1;
			else if (&fill_addr)
				clearing <= 1'b0;

			if (clearing && !cart_start)
				fill_addr <= fill_addr + 1'b1;
			else
				fill_addr <= '0;
		end
	end

	assign fill_we = clearing;

	always_comb begin
		case (wram_init)
			PATTERN_9966: fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
			PATTERN_00FF: fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
			FILL_55:      fill_data = 8'h55;
			default:      fill_data = 8'hFF;
		endcase
	end

	// A clear always starts from the bottom of the RAM
	a_clear_starts_at_zero: assert property (
		@(posedge clk_sys) disable iff (RESET)
		$rose(clearing) |-> (fill_addr == '0)
	);

endmodule

// ==== files.f ====
+incdir+verif
design/cart_pkg.sv
design/download_decoder.sv
design/rom_header_parser.sv
design/wram_clear_sequencer.sv
design/work_ram.sv
design/cheat_code_assembler.sv
design/backup_ram_sequencer.sv
design/cart_loader_top.sv
verif/cart_loader_tb.sv

// ==== verif/tb_stim_table.svh ====
`ifndef TB_STIM_TABLE_SVH
`define TB_STIM_TABLE_SVH

	// ======================================================================
	// Header cases
	// ======================================================================

	localparam int N_ROWS = 6;

	// Menu settings for each download
	rom_layout_e row_layout [N_ROWS] = '{AUTO, NO_HEADER_LOROM, LOROM, HIROM, EXHIROM, AUTO};
	logic [1:0]  row_region [N_ROWS] = '{2'd0, 2'd1, 2'd0, 2'd2, 2'd3, 2'd0};
	wram_init_e  row_init   [N_ROWS] = '{PATTERN_9966, PATTERN_00FF, FILL_55, FILL_FF,
		PATTERN_9966, PATTERN_00FF};

	// Words at offsets 0 and 2, then ROM size (bits 11:8) and RAM size (bits 3:0)
	logic [15:0] row_word0    [N_ROWS] = '{16'h0A19, 16'h3344, 16'h0000, 16'h1234,
		16'h0000, 16'h2000};
	logic [15:0] row_word2    [N_ROWS] = '{16'h0100, 16'h0100, 16'h0000, 16'h0000,
		16'h0100, 16'h0000};
	logic [15:0] row_rom_word [N_ROWS] = '{16'h0B00, 16'h0700, 16'h0A00, 16'h0B00,
		16'h0D00, 16'h0900};
	logic [15:0] row_ram_word [N_ROWS] = '{16'h0005, 16'h0002, 16'h0003, 16'h0000,
		16'h0005, 16'h0004};

	// Expected results
	logic [7:0]        row_type     [N_ROWS] = '{8'h0A, 8'h00, 8'h00, 8'h01, 8'h02, 8'h20};
	logic [MASK_W-1:0] row_rom_mask [N_ROWS] = '{24'h07FFFF, 24'h3FFFFF, 24'h0FFFFF,
		24'h1FFFFF, 24'h7FFFFF, 24'h3FFFFF};
	logic [MASK_W-1:0] row_ram_mask [N_ROWS] = '{24'h0007FF, 24'h000000, 24'h001FFF,
		24'h000000, 24'h007FFF, 24'h000000};
	logic              row_pal      [N_ROWS] = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0};

	// ROM size word after the 512-byte copier header
	function automatic logic [24:0] size_field_addr(input rom_layout_e layout);
		case (layout)
			HIROM:   return 25'h200 + 25'hFFD6;
			EXHIROM: return 25'h200 + 25'h40FFD6;
			default: return 25'h200 + 25'h7FD6;
		endcase
	endfunction

	task automatic run_download(input int r);
		logic [24:0] base;
		base = size_field_addr(row_layout[r]);
		@(negedge clk_sys);
		rom_layout = row_layout[r];
		region_sel = row_region[r];
		wram_init  = row_init[r];
		dl_index   = STREAM_CART;
		dl_active  = 1'b1;
		write_word(25'd0, row_word0[r]);
		write_word(25'd2, row_word2[r]);
		write_word(base, row_rom_word[r]);
		write_word(base + 25'd2, row_ram_word[r]);
		repeat (2) @(negedge clk_sys);
		if (cart_active !== 1'b1) begin
			err_count++;
			$display("ERR %0t: row %0d cart_active low during download", $time, r);
		end
		dl_active = 1'b0;
	endtask

	task automatic apply_table();
		for (int r = 0; r < N_ROWS; r++) begin
			run_download(r);
			if (clearing !== 1'b1) begin
				err_count++;
				$display("ERR %0t: row %0d clearing not active", $time, r);
			end
			wait_level(W_CLEARING, 1'b0, "clearing to fall");
			if (rom_type !== row_type[r]) begin
				err_count++;
				$display("ERR %0t: row %0d rom_type %h, expected %h", $time, r, rom_type,
					row_type[r]);
			end
			if (rom_mask !== row_rom_mask[r]) begin
				err_count++;
				$display("ERR %0t: row %0d rom_mask %h, expected %h", $time, r, rom_mask,
					row_rom_mask[r]);
			end
			if (ram_mask !== row_ram_mask[r]) begin
				err_count++;
				$display("ERR %0t: row %0d ram_mask %h, expected %h", $time, r, ram_mask,
					row_ram_mask[r]);
			end
			if (pal !== row_pal[r]) begin
				err_count++;
				$display("ERR %0t: row %0d pal %b, expected %b", $time, r, pal, row_pal[r]);
			end
			check_fill(row_init[r]);
		end
	endtask

`endif

// ==== verif/cart_loader_tb.sv ====
module cart_loader_tb import cart_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int WRAM_ADDR_W = 10;

	// Selectors for the bounded wait
	localparam int W_CLEARING = 0;
	localparam int W_BUSY     = 1;
	localparam int W_CHEAT    = 2;

	logic                   clk_sys;
	logic                   RESET;
	logic                   dl_active;
	logic                   dl_wr;
	logic [7:0]             dl_index;
	logic [24:0]            dl_addr;
	logic [15:0]            dl_data;
	rom_layout_e            rom_layout;
	logic [1:0]             region_sel;
	wram_init_e             wram_init;
	logic                   osd_open;
	logic                   autosave;
	logic                   bk_load_req;
	logic                   bk_save_req;
	logic                   img_mounted;
	logic                   img_readonly;
	logic                   img_size_nz;
	logic                   sd_ack;
	logic                   sd_rd;
	logic                   sd_wr;
	logic [31:0]            sd_lba;
	logic                   bsram_write;
	logic [WRAM_ADDR_W-1:0] sys_addr;
	logic [7:0]             sys_wdata;
	logic                   sys_we;
	logic [7:0]             sys_rdata;
	logic                   cart_active;
	logic [7:0]             rom_type;
	logic [MASK_W-1:0]      rom_mask;
	logic [MASK_W-1:0]      ram_mask;
	logic                   pal;
	logic                   clearing;
	logic [CHEAT_W-2:0]     cheat_code;
	logic                   cheat_valid;
	logic                   bk_busy;
	logic                   bk_pending;
	logic                   bk_enabled;

	int          err_count     = 0;
	int          timeout_count = 0;
	int          valid_count   = 0;
	logic [15:0] lfsr_state    = 16'd1318;

	cart_loader_top #(.WRAM_ADDR_W(WRAM_ADDR_W)) i_cart_loader_top (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// Counts cheat strobes over the whole run
	always @(posedge clk_sys) begin
		if (!RESET && cheat_valid)
			valid_count <= valid_count + 1;
	end

	// ======================================================================
	// Helpers
	// ======================================================================

	// Galois LFSR, taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	// Power-on contents for one work-RAM byte
	function automatic logic [7:0] fill_value(input wram_init_e init,
			input logic [WRAM_ADDR_W-1:0] a);
		case (init)
			PATTERN_9966: return (a[8] ^ a[2]) ? 8'h66 : 8'h99;
			PATTERN_00FF: return (a[9] ^ a[0]) ? 8'hFF : 8'h00;
			FILL_55:      return 8'h55;
			default:      return 8'hFF;
		endcase
	endfunction

	function automatic logic probe(input int sel);
		case (sel)
			W_CLEARING: return clearing;
			W_BUSY:     return bk_busy;
			default:    return valid_count != 0;
		endcase
	endfunction

	task automatic wait_level(input int sel, input logic level, input string what);
		int n;
		n = 0;
		while (probe(sel) !== level && n < 5000) begin
			@(negedge clk_sys);
			n++;
		end
		if (probe(sel) !== level) begin
			timeout_count++;
			$display("Timed out waiting for %s", what);
		end
	endtask

	task automatic write_word(input logic [24:0] addr, input logic [15:0] data);
		dl_addr = addr;
		dl_data = data;
		dl_wr   = 1'b1;
		@(negedge clk_sys);
		dl_wr = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic check_fill(input wram_init_e init);
		logic [31:0]            bits;
		logic [WRAM_ADDR_W-1:0] addr;
		for (int i = 0; i < 16; i++) begin
			take_bits(WRAM_ADDR_W, bits);
			addr = bits[WRAM_ADDR_W-1:0];
			sys_addr = addr;
			@(negedge clk_sys);
			if (sys_rdata !== fill_value(init, addr)) begin
				err_count++;
				$display("ERR %0t: wram[%h] = %h, expected %h", $time, addr, sys_rdata,
					fill_value(init, addr));
			end
		end
	endtask

	// ======================================================================
	// Cheat stream and SD block side
	// ======================================================================

	task automatic check_cheat();
		logic [31:0]  bits;
		logic [15:0]  w [8];
		logic [127:0] expect_code;
		@(negedge clk_sys);
		dl_index  = STREAM_CHEAT;
		dl_active = 1'b1;
		for (int i = 0; i < 8; i++) begin
			take_bits(16, bits);
			w[i] = bits[15:0];
			write_word(25'(2 * i), w[i]);
		end
		wait_level(W_CHEAT, 1'b1, "cheat_valid");
		repeat (4) @(negedge clk_sys);
		if (cart_active !== 1'b0) begin
			err_count++;
			$display("ERR %0t: cart_active high on the cheat stream", $time);
		end
		dl_active = 1'b0;
		// Flags, address, compare, replace, each high word first
		expect_code = {w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]};
		if (valid_count != 1) begin
			err_count++;
			$display("ERR %0t: cheat_valid pulsed %0d times, expected 1", $time, valid_count);
		end
		if (cheat_code !== expect_code) begin
			err_count++;
			$display("ERR %0t: cheat_code %h, expected %h", $time, cheat_code, expect_code);
		end
	endtask

	// Acts as the SD side, acks every block request until the transfer ends
	task automatic serve_blocks(input logic want_wr, input int blocks, input string what);
		int n;
		int t;
		n = 0;
		t = 0;
		wait_level(W_BUSY, 1'b1, {what, " to start"});
		while (bk_busy && t < 2000) begin
			if (sd_rd || sd_wr) begin
				if (sd_wr !== want_wr || sd_rd !== !want_wr) begin
					err_count++;
					$display("ERR %0t: %s request rd=%b wr=%b", $time, what, sd_rd, sd_wr);
				end
				if (sd_lba !== 32'(n)) begin
					err_count++;
					$display("ERR %0t: %s lba %0d, expected %0d", $time, what, sd_lba, n);
				end
				sd_ack = 1'b1;
				repeat (2) @(negedge clk_sys);
				sd_ack = 1'b0;
				n++;
			end
			@(negedge clk_sys);
			t++;
		end
		if (bk_busy) begin
			timeout_count++;
			$display("Timed out waiting for the %s transfer to finish", what);
		end
		if (n != blocks) begin
			err_count++;
			$display("ERR %0t: %s issued %0d blocks, expected %0d", $time, what, n, blocks);
		end
	endtask

	`include "tb_stim_table.svh"

	// ======================================================================
	// Main sequence
	// ======================================================================

	initial begin
		int blocks;
		RESET        = 1'b1;
		dl_active    = 1'b0;
		dl_wr        = 1'b0;
		dl_index     = 8'h00;
		dl_addr      = '0;
		dl_data      = '0;
		rom_layout   = AUTO;
		region_sel   = 2'd0;
		wram_init    = PATTERN_9966;
		osd_open     = 1'b0;
		autosave     = 1'b0;
		bk_load_req  = 1'b0;
		bk_save_req  = 1'b0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size_nz  = 1'b0;
		sd_ack       = 1'b0;
		bsram_write  = 1'b0;
		sys_addr     = '0;
		sys_wdata    = '0;
		sys_we       = 1'b0;
		repeat (16) @(negedge clk_sys);
		RESET = 1'b0;
		@(negedge clk_sys);
		if (clearing || cheat_valid || sd_rd || sd_wr || bk_busy || bk_pending || bk_enabled) begin
			err_count++;
			$display("ERR %0t: status outputs not idle after reset", $time);
		end

		apply_table();
		check_cheat();

		// Autoload from a mounted, writable save image
		img_mounted = 1'b1;
		img_size_nz = 1'b1;
		run_download(2);
		blocks = int'(row_ram_mask[2] >> 9) + 1;
		serve_blocks(1'b0, blocks, "autoload");
		if (bk_enabled !== 1'b1) begin
			err_count++;
			$display("ERR %0t: bk_enabled low after autoload", $time);
		end

		// System write marks the save RAM dirty
		bsram_write = 1'b1;
		@(negedge clk_sys);
		bsram_write = 1'b0;
		@(negedge clk_sys);
		if (bk_pending !== 1'b1) begin
			err_count++;
			$display("ERR %0t: bk_pending not set by bsram_write", $time);
		end
		autosave = 1'b1;
		osd_open = 1'b1;
		serve_blocks(1'b1, blocks, "autosave");
		if (bk_pending !== 1'b0) begin
			err_count++;
			$display("ERR %0t: bk_pending still set after save", $time);
		end
		osd_open = 1'b0;
		repeat (4) @(negedge clk_sys);

		$display("Errors: %0d wrong values, %0d timeouts", err_count, timeout_count);
		if (err_count == 0 && timeout_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule
